// File: cdb_top.f
rtl/cdb_pkg.sv
rtl/cdb_arbiter.sv
rtl/cdb.sv
rtl/rob.sv
rtl/cdb_top.sv
tests/tb_cdb_top.sv

// File: run.sh
#!/bin/sh
# Compile the CDB/ROB subsystem with its testbench and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f cdb_top.f \
  --top-module tb_cdb_top -o tb_cdb_top

# The simulator exits non-zero on a failed run; the search below decides
out=$(./obj_dir/tb_cdb_top 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
  exit 0
fi
exit 1

// File: tests/tb_cdb_top.sv
// ----------------------------
// Testbench for the CDB and ROB write-back path
// LFSR traffic against a queue model plus round-robin, back-pressure and flush
// ----------------------------

module tb_cdb_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int RAND_CYCLES  = 600;
  localparam int FILL_CYCLES  = 60;
  // Directed steps, random phases, fill phase and drain
  localparam int N_OPS        = 40 + 3 * RAND_CYCLES + FILL_CYCLES;
  localparam int OP_BOUND     = 40;
  localparam logic [31:0] LFSR_MASK = 32'hD0000001;

  // One allocated entry as the model sees it
  typedef struct packed {
    cdb_pkg::rob_idx_t        idx;
    logic [cdb_pkg::RD_W-1:0] rd;
  } alloc_rec_t;

  // ----------------------------
  // DUT ports
  // ----------------------------
  logic clk_i;
  logic rst_n_i;
  logic flush_i;
  logic max_prio_valid_i;
  logic max_prio_ready_o;
  cdb_pkg::cdb_data_t max_prio_data_i;
  logic [cdb_pkg::RS_N-1:0] rs_valid_i;
  logic [cdb_pkg::RS_N-1:0] rs_ready_o;
  cdb_pkg::cdb_data_t [cdb_pkg::RS_N-1:0] rs_data_i;
  logic alloc_valid_i;
  logic alloc_ready_o;
  cdb_pkg::rob_alloc_t alloc_data_i;
  cdb_pkg::rob_idx_t alloc_idx_o;
  logic commit_valid_o;
  logic commit_ready_i;
  cdb_pkg::rob_commit_t commit_data_o;

  // ----------------------------
  // Model state
  // ----------------------------
  logic [31:0] lfsr_q;
  alloc_rec_t alloc_q [$];
  // Allocated entries whose result is not on any source yet
  cdb_pkg::rob_idx_t unsent [$];
  int grants [$];
  cdb_pkg::cdb_data_t exp_res [cdb_pkg::ROB_DEPTH];
  bit sent [cdb_pkg::ROB_DEPTH];
  cdb_pkg::rob_idx_t tail_m;
  int rr_m;
  logic held_v;
  cdb_pkg::rob_commit_t held_d;
  bit failed;

  // Source slots with slot 0 as the max-priority port
  logic src_v [cdb_pkg::MAX_EU_N];
  cdb_pkg::cdb_data_t src_d [cdb_pkg::MAX_EU_N];
  logic al_v;
  cdb_pkg::rob_alloc_t al_d;
  logic flush_req;

  // Traffic knobs as thresholds out of 128
  int alloc_thr;
  int send_thr;
  int commit_thr;
  int alloc_left;
  logic mp_en;

  cdb_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    #((N_OPS * OP_BOUND + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not finish within its cycle budget");
    failed = 1'b1;
    stop_run();
  end

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      failed = 1'b1;
      $display("[FAIL] %0d ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_MASK) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic chance(input int thr);
    return int'(rand_bits(7)) < thr;
  endfunction

  task automatic clear_model();
    alloc_q.delete();
    unsent.delete();
    foreach (sent[i]) sent[i] = 1'b0;
    foreach (src_v[i]) src_v[i] = 1'b0;
    tail_m = '0;
    rr_m   = 0;
    held_v = 1'b0;
    al_v   = 1'b0;
  endtask

  task automatic take_result(input int slot, input cdb_pkg::cdb_data_t d);
    exp_res[d.rob_idx] = d;
    sent[d.rob_idx]    = 1'b1;
    src_v[slot]        = 1'b0;
  endtask

  // ----------------------------
  // Check one clock edge and update the model
  // ----------------------------
  task automatic observe();
    logic alloc_fire;
    logic bus_open;
    logic exp_cv;
    logic [cdb_pkg::RS_N-1:0] exp_rs;
    int win;
    alloc_rec_t front;
    check_eq(64'(alloc_ready_o), 64'(alloc_q.size() < cdb_pkg::ROB_DEPTH && !flush_i),
             "alloc_ready_o");
    alloc_fire = alloc_valid_i && alloc_ready_o;
    // Allocation owns the ROB write port
    bus_open = !alloc_fire && !flush_i;
    win = -1;
    for (int i = 0; i < cdb_pkg::RS_N; i++) begin
      if (win < 0 && rs_valid_i[(rr_m + i) % cdb_pkg::RS_N]) begin
        win = (rr_m + i) % cdb_pkg::RS_N;
      end
    end
    exp_rs = '0;
    if (!max_prio_valid_i && win >= 0) begin
      exp_rs[win] = bus_open;
    end
    check_eq(64'(max_prio_ready_o), 64'(max_prio_valid_i && bus_open), "max_prio_ready_o");
    check_eq(64'(rs_ready_o), 64'(exp_rs), "rs_ready_o");
    exp_cv = alloc_q.size() > 0 && sent[alloc_q[0].idx] && !flush_i;
    check_eq(64'(commit_valid_o), 64'(exp_cv), "commit_valid_o");
    if (held_v && !flush_i) begin
      check_eq(64'(commit_data_o), 64'(held_d), "commit_data_o under back-pressure");
    end
    if (flush_i) begin
      clear_model();
    end else begin
      if (commit_valid_o && commit_ready_i) begin
        front = alloc_q.pop_front();
        check_eq(64'(commit_data_o.rob_idx), 64'(front.idx), "commit rob_idx");
        check_eq(64'(commit_data_o.rd), 64'(front.rd), "commit rd");
        check_eq(64'(commit_data_o.res_value), 64'(exp_res[front.idx].res_value),
                 "commit res_value");
        check_eq(64'({commit_data_o.except_raised, commit_data_o.except_cause}),
                 64'({exp_res[front.idx].except_raised, exp_res[front.idx].except_cause}),
                 "commit exception");
        sent[front.idx] = 1'b0;
        held_v = 1'b0;
      end else begin
        held_v = commit_valid_o;
        held_d = commit_data_o;
      end
      if (max_prio_valid_i && max_prio_ready_o) begin
        take_result(0, max_prio_data_i);
      end
      for (int k = 0; k < cdb_pkg::RS_N; k++) begin
        if (rs_valid_i[k] && rs_ready_o[k]) begin
          take_result(k + 1, rs_data_i[k]);
          grants.push_back(k);
          rr_m = (k + 1) % cdb_pkg::RS_N;
        end
      end
      if (alloc_fire) begin
        check_eq(64'(alloc_idx_o), 64'(tail_m), "alloc_idx_o");
        alloc_q.push_back(alloc_rec_t'{idx: tail_m, rd: alloc_data_i.rd});
        unsent.push_back(tail_m);
        tail_m = tail_m + 1'b1;
        al_v = 1'b0;
      end
    end
  endtask

  // ----------------------------
  // Pick the next inputs
  // ----------------------------
  task automatic drive();
    logic [31:0] r;
    int pos;
    logic [cdb_pkg::RS_N-1:0] rs_v;
    cdb_pkg::cdb_data_t [cdb_pkg::RS_N-1:0] rs_d;
    // Idle sources take a random unsent index, so results arrive out of order
    for (int s = 0; s < cdb_pkg::MAX_EU_N; s++) begin
      if (!src_v[s] && unsent.size() > 0 && (s > 0 || mp_en) && chance(send_thr)) begin
        pos = int'(rand_bits(3)) % unsent.size();
        r = rand_bits(3);
        src_d[s].rob_idx       = unsent[pos];
        src_d[s].res_value     = rand_bits(32);
        src_d[s].except_raised = r[2];
        src_d[s].except_cause  = cdb_pkg::except_cause_t'(r[1:0]);
        unsent.delete(pos);
        src_v[s] = 1'b1;
      end
    end
    if (!al_v && alloc_left > 0 && chance(alloc_thr)) begin
      r = rand_bits(cdb_pkg::RD_W);
      al_d.rd = r[cdb_pkg::RD_W-1:0];
      al_v = 1'b1;
      alloc_left--;
    end
    for (int k = 0; k < cdb_pkg::RS_N; k++) begin
      rs_v[k] = src_v[k + 1];
      rs_d[k] = src_d[k + 1];
    end
    max_prio_valid_i <= src_v[0];
    max_prio_data_i  <= src_d[0];
    rs_valid_i       <= rs_v;
    rs_data_i        <= rs_d;
    alloc_valid_i    <= al_v;
    alloc_data_i     <= al_d;
    commit_ready_i   <= chance(commit_thr);
    flush_i          <= flush_req;
    flush_req = 1'b0;
  endtask

  task automatic step();
    @(posedge clk_i);
    observe();
    drive();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) step();
  endtask

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial begin
    int rr_exp [4];
    rr_exp = '{0, 1, 2, 0};
    lfsr_q = 32'h60ea910c;
    failed = 1'b0;
    flush_req = 1'b0;
    clear_model();
    al_d = '0;
    foreach (src_d[i]) src_d[i] = '0;
    alloc_thr = 0;
    send_thr = 0;
    commit_thr = 0;
    alloc_left = 0;
    mp_en = 1'b0;
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    max_prio_valid_i = 1'b0;
    max_prio_data_i = '0;
    rs_valid_i = '0;
    rs_data_i = '0;
    alloc_valid_i = 1'b0;
    alloc_data_i = '0;
    commit_ready_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_eq(64'(alloc_idx_o), 64'(0), "alloc_idx_o after reset");
    observe();
    drive();

    // Round-robin from the reset pointer with all stations loaded at once
    alloc_thr = 128;
    alloc_left = 4;
    commit_thr = 128;
    while (alloc_q.size() < 4) step();
    send_thr = 128;
    grants.delete();
    while (grants.size() < 4) step();
    for (int i = 0; i < 4; i++) begin
      check_eq(64'(grants[i]), 64'(rr_exp[i]), "round-robin grant order");
    end

    // Mixed random traffic
    alloc_thr = 80;
    alloc_left = 1 << 20;
    send_thr = 40;
    commit_thr = 96;
    mp_en = 1'b1;
    run_cycles(RAND_CYCLES);

    // Commit stalled until the ROB fills
    commit_thr = 0;
    alloc_thr = 128;
    run_cycles(FILL_CYCLES);
    check_eq(64'(alloc_q.size()), 64'(cdb_pkg::ROB_DEPTH), "entries held with commit stalled");
    commit_thr = 64;
    alloc_thr = 64;
    send_thr = 48;
    run_cycles(RAND_CYCLES / 2);

    // Flush in the middle of traffic
    flush_req = 1'b1;
    run_cycles(RAND_CYCLES);

    // Drain
    alloc_left = 0;
    send_thr = 128;
    commit_thr = 128;
    while (alloc_q.size() > 0 || al_v) step();

    if (!failed) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

// File: rtl/cdb_top.sv
// ----------------------------
// Write-back subsystem top
// CDB feeding the reorder buffer
// ----------------------------

module cdb_top (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      flush_i,

  // Max-priority execution unit
  input  logic                                      max_prio_valid_i,
  output logic                                      max_prio_ready_o,
  input  cdb_pkg::cdb_data_t                        max_prio_data_i,

  // Reservation stations
  input  logic [cdb_pkg::RS_N-1:0]                  rs_valid_i,
  output logic [cdb_pkg::RS_N-1:0]                  rs_ready_o,
  input  cdb_pkg::cdb_data_t [cdb_pkg::RS_N-1:0]    rs_data_i,

  // Allocation
  input  logic                                      alloc_valid_i,
  output logic                                      alloc_ready_o,
  input  cdb_pkg::rob_alloc_t                       alloc_data_i,
  output cdb_pkg::rob_idx_t                         alloc_idx_o,

  // Commit
  output logic                                      commit_valid_o,
  input  logic                                      commit_ready_i,
  output cdb_pkg::rob_commit_t                      commit_data_o
);

  // ----------------------------
  // CDB to ROB
  // ----------------------------
  logic               rob_ready;
  logic               cdb_valid;
  cdb_pkg::cdb_data_t cdb_data;

  // Bus with its arbiter
  cdb u_cdb (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .max_prio_valid_i(max_prio_valid_i),
    .max_prio_ready_o(max_prio_ready_o),
    .max_prio_data_i (max_prio_data_i),
    .rs_valid_i      (rs_valid_i),
    .rs_ready_o      (rs_ready_o),
    .rs_data_i       (rs_data_i),
    .rob_ready_i     (rob_ready),
    .valid_o         (cdb_valid),
    .data_o          (cdb_data)
  );

  // Reorder buffer
  rob u_rob (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .alloc_valid_i (alloc_valid_i),
    .alloc_ready_o (alloc_ready_o),
    .alloc_data_i  (alloc_data_i),
    .alloc_idx_o   (alloc_idx_o),
    .cdb_valid_i   (cdb_valid),
    .cdb_ready_o   (rob_ready),
    .cdb_data_i    (cdb_data),
    .commit_valid_o(commit_valid_o),
    .commit_ready_i(commit_ready_i),
    .commit_data_o (commit_data_o)
  );

endmodule

// File: rtl/rob.sv
// ----------------------------
// Reorder buffer
// In-order allocation and commit, out-of-order result write-back
// ----------------------------

module rob (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,

  // Allocation from issue
  input  logic                  alloc_valid_i,
  output logic                  alloc_ready_o,
  input  cdb_pkg::rob_alloc_t   alloc_data_i,
  output cdb_pkg::rob_idx_t     alloc_idx_o,

  // Write-back from the CDB
  input  logic                  cdb_valid_i,
  output logic                  cdb_ready_o,
  input  cdb_pkg::cdb_data_t    cdb_data_i,

  // Commit port
  output logic                  commit_valid_o,
  input  logic                  commit_ready_i,
  output cdb_pkg::rob_commit_t  commit_data_o
);

  // Payload part of one entry
  typedef struct packed {
    logic [cdb_pkg::RD_W-1:0] rd;
    logic [cdb_pkg::XLEN-1:0] res_value;
    logic                     except_raised;
    cdb_pkg::except_cause_t   except_cause;
  } rob_entry_t;

  // ----------------------------
  // State
  // ----------------------------

  // Entry array, payload only
  rob_entry_t                      entry_q [cdb_pkg::ROB_DEPTH];

  // Per-entry control bits
  logic [cdb_pkg::ROB_DEPTH-1:0]   valid_q;
  logic [cdb_pkg::ROB_DEPTH-1:0]   done_q;

  // Circular pointers with wrap bit
  cdb_pkg::rob_ptr_t               head_q;
  cdb_pkg::rob_ptr_t               tail_q;

  cdb_pkg::rob_idx_t               head_idx;
  cdb_pkg::rob_idx_t               tail_idx;
  logic                            full;

  // Handshake results
  logic                            alloc_fire;
  logic                            cdb_fire;
  logic                            commit_fire;

  assign head_idx = head_q[cdb_pkg::ROB_IDX_W-1:0];
  assign tail_idx = tail_q[cdb_pkg::ROB_IDX_W-1:0];

  // Same slot, different lap
  assign full = (head_idx == tail_idx) &&
                (head_q[cdb_pkg::ROB_IDX_W] != tail_q[cdb_pkg::ROB_IDX_W]);

  // ----------------------------
  // Handshakes
  // ----------------------------
  assign alloc_ready_o = ~full & ~flush_i;
  assign alloc_idx_o   = tail_idx;
  assign alloc_fire    = alloc_valid_i & alloc_ready_o;

  // Write port busy with allocation, CDB waits a cycle
  assign cdb_ready_o = ~alloc_fire & ~flush_i;
  assign cdb_fire    = cdb_valid_i & cdb_ready_o;

  // Head goes out once its result is in
  assign commit_valid_o = valid_q[head_idx] & done_q[head_idx] & ~flush_i;
  assign commit_fire    = commit_valid_o & commit_ready_i;

  always_comb begin
    commit_data_o.rob_idx       = head_idx;
    commit_data_o.rd            = entry_q[head_idx].rd;
    commit_data_o.res_value     = entry_q[head_idx].res_value;
    commit_data_o.except_raised = entry_q[head_idx].except_raised;
    commit_data_o.except_cause  = entry_q[head_idx].except_cause;
  end

  // ----------------------------
  // Control state
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      // New entry at the tail, result not yet in
      if (alloc_fire) begin
        valid_q[tail_idx] <= 1'b1;
        done_q[tail_idx]  <= 1'b0;
        tail_q            <= tail_q + 1'b1;
      end
      // Results for stale slots are dropped
      if (cdb_fire && valid_q[cdb_data_i.rob_idx]) begin
        done_q[cdb_data_i.rob_idx] <= 1'b1;
      end
      // Retire the head
      if (commit_fire) begin
        valid_q[head_idx] <= 1'b0;
        done_q[head_idx]  <= 1'b0;
        head_q            <= head_q + 1'b1;
      end
    end
  end

  // ----------------------------
  // Entry write port
  // ----------------------------

  // Allocation first, otherwise the CDB result
  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      entry_q[tail_idx].rd <= alloc_data_i.rd;
    end else if (cdb_fire) begin
      entry_q[cdb_data_i.rob_idx].res_value     <= cdb_data_i.res_value;
      entry_q[cdb_data_i.rob_idx].except_raised <= cdb_data_i.except_raised;
      entry_q[cdb_data_i.rob_idx].except_cause  <= cdb_data_i.except_cause;
    end
  end

endmodule

// File: rtl/cdb.sv
// ----------------------------
// Common data bus
// Arbitrates result sources and broadcasts the winner
// ----------------------------

module cdb (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      flush_i,

  // Max-priority unit
  input  logic                                      max_prio_valid_i,
  output logic                                      max_prio_ready_o,
  input  cdb_pkg::cdb_data_t                        max_prio_data_i,

  // Reservation stations
  input  logic [cdb_pkg::RS_N-1:0]                  rs_valid_i,
  output logic [cdb_pkg::RS_N-1:0]                  rs_ready_o,
  input  cdb_pkg::cdb_data_t [cdb_pkg::RS_N-1:0]    rs_data_i,

  // ROB side
  input  logic                                      rob_ready_i,
  output logic                                      valid_o,
  output cdb_pkg::cdb_data_t                        data_o
);

  // Arbiter decision
  logic               served_max_prio;
  cdb_pkg::eu_idx_t   served;

  // Station index behind the served number
  cdb_pkg::rs_idx_t   rs_idx;
  cdb_pkg::cdb_data_t rs_mux_data;

  // ----------------------------
  // Arbiter
  // ----------------------------
  cdb_arbiter u_cdb_arbiter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .max_prio_valid_i (max_prio_valid_i),
    .max_prio_ready_o (max_prio_ready_o),
    .valid_i          (rs_valid_i),
    .ready_o          (rs_ready_o),
    .rob_ready_i      (rob_ready_i),
    .rob_valid_o      (valid_o),
    .served_max_prio_o(served_max_prio),
    .served_o         (served)
  );

  // ----------------------------
  // Output mux
  // ----------------------------

  // Served number minus one, kept in range when nobody is served
  assign rs_idx = (served == '0) ? '0 : cdb_pkg::rs_idx_t'(served - 1'b1);

  assign rs_mux_data = rs_data_i[rs_idx];

  // Max-priority data overrides the stations
  assign data_o = served_max_prio ? max_prio_data_i : rs_mux_data;

endmodule

// File: rtl/cdb_arbiter.sv
// ----------------------------
// CDB arbiter
// Max-priority port always wins, reservation stations served round-robin
// ----------------------------

module cdb_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,

  // Max-priority unit handshake
  input  logic                          max_prio_valid_i,
  output logic                          max_prio_ready_o,

  // Reservation station handshakes
  input  logic [cdb_pkg::RS_N-1:0]      valid_i,
  output logic [cdb_pkg::RS_N-1:0]      ready_o,

  // ROB handshake
  input  logic                          rob_ready_i,
  output logic                          rob_valid_o,

  // Winner of this cycle
  output logic                          served_max_prio_o,
  output cdb_pkg::eu_idx_t              served_o
);

  // First station to look at in the search
  cdb_pkg::rs_idx_t rr_ptr_q;

  // Search result among the stations
  logic             rs_found;
  cdb_pkg::rs_idx_t rs_sel;

  // Bus can move a result this cycle
  logic             bus_open;
  logic             rs_xfer;

  assign bus_open = rob_ready_i & ~flush_i;

  // ----------------------------
  // Round-robin search
  // ----------------------------
  always_comb begin
    int cand;
    rs_found = 1'b0;
    rs_sel   = '0;
    for (int i = 0; i < cdb_pkg::RS_N; i++) begin
      // Wrap around the station count, which need not be a power of two
      cand = int'(rr_ptr_q) + i;
      if (cand >= cdb_pkg::RS_N) begin
        cand = cand - cdb_pkg::RS_N;
      end
      if (!rs_found && valid_i[cand]) begin
        rs_found = 1'b1;
        rs_sel   = cdb_pkg::rs_idx_t'(cand);
      end
    end
  end

  // ----------------------------
  // Grant
  // ----------------------------
  always_comb begin
    served_max_prio_o = max_prio_valid_i;
    served_o          = '0;
    ready_o           = '0;
    // Station k reported as k+1, zero is the max-priority port
    if (!max_prio_valid_i && rs_found) begin
      served_o        = cdb_pkg::eu_idx_t'(rs_sel) + 1'b1;
      ready_o[rs_sel] = bus_open;
    end
  end

  // Max-priority port needs only the ROB
  assign max_prio_ready_o = max_prio_valid_i & bus_open;

  // Broadcast when anything is pending and the ROB can take it
  assign rob_valid_o = (max_prio_valid_i | (|valid_i)) & bus_open;

  assign rs_xfer = |(ready_o & valid_i);

  // ----------------------------
  // Pointer update
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      rr_ptr_q <= '0;
    end else if (rs_xfer) begin
      // Start after the station just served
      if (rs_sel == cdb_pkg::rs_idx_t'(cdb_pkg::RS_N - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= rs_sel + 1'b1;
      end
    end
  end

endmodule

// File: rtl/cdb_pkg.sv
// ----------------------------
// CDB and ROB shared definitions
// Sizes, exception causes and the result, allocation and commit records
// ----------------------------

package cdb_pkg;

  // ----------------------------
  // Sizes
  // ----------------------------

  // Result sources: one max-priority port plus the reservation stations
  localparam int MAX_EU_N = 4;
  localparam int RS_N = MAX_EU_N - 1;
  localparam int EU_IDX_W = $clog2(MAX_EU_N);
  localparam int RS_IDX_W = $clog2(RS_N);

  // Reorder buffer geometry
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

  // Datapath
  localparam int XLEN = 32;
  localparam int RD_W = 5;

  // Index types, also used for width casts
  typedef logic [EU_IDX_W-1:0] eu_idx_t;
  typedef logic [RS_IDX_W-1:0] rs_idx_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  // Extra MSB is the wrap bit
  typedef logic [ROB_IDX_W:0] rob_ptr_t;

  // ----------------------------
  // Exception causes
  // ----------------------------
  typedef enum logic [1:0] {
    EXC_NONE          = 2'd0,
    EXC_ILLEGAL_INSTR = 2'd1,
    EXC_MISALIGNED    = 2'd2,
    EXC_ACCESS_FAULT  = 2'd3
  } except_cause_t;

  // ----------------------------
  // Records
  // ----------------------------

  // One result on the bus
  typedef struct packed {
    rob_idx_t          rob_idx;
    logic [XLEN-1:0]   res_value;
    logic              except_raised;
    except_cause_t     except_cause;
  } cdb_data_t;

  // Written at allocation
  typedef struct packed {
    logic [RD_W-1:0] rd;
  } rob_alloc_t;

  // One retired instruction
  typedef struct packed {
    rob_idx_t          rob_idx;
    logic [RD_W-1:0]   rd;
    logic [XLEN-1:0]   res_value;
    logic              except_raised;
    except_cause_t     except_cause;
  } rob_commit_t;

endpackage
